// File: verilog/l2_pkg.sv
/*
 * L2 arbiter shared definitions
 * Request field types, requestor ID, port count and the control FSM states
 */
package l2_pkg;

        typedef logic [29:0] l2_addr_t;         // Word address
        typedef logic [31:0] l2_data_t;         // Write or read data word
        typedef logic [0:0]  l2_id_t;           // Requestor number

        // Round-robin logic assumes exactly two requestors
        localparam int L2_NUM_PORTS = 2;

        // Request entry packing, MSB first
        // {addr[62:33], rnw[32], wdata[31:0]}
        localparam int l2_req_width = $bits(l2_addr_t) + 1 + $bits(l2_data_t);

        typedef logic [l2_req_width-1:0] l2_req_t;

        // Output register occupancy
        typedef enum logic {
                st_idle,                        // Output register empty
                st_loaded                       // Request waiting for memory ack
        } l2_ctrl_state_t;

endpackage

// File: verilog/l2_fifo.sv
/*
 * Synchronous FIFO
 * Distributed memory with read and write indices plus a one-hot occupancy
 * vector; valid and full are taken from its end bits.
 * Depth 1 collapses to a single data register and a valid flag
 */
`timescale 1ns/1ps

module l2_fifo #(
        parameter int DATA_WIDTH = 32,
        parameter int FIFO_DEPTH = 4
) (
        input  logic                  clk,
        input  logic                  rst,
        input  logic                  push,
        input  logic                  pop,
        input  logic [DATA_WIDTH-1:0] data_in,
        output logic [DATA_WIDTH-1:0] data_out,
        output logic                  valid,
        output logic                  full
);

        generate if (FIFO_DEPTH == 1) begin : g_single
                logic held;                     // Entry present

                always_ff @(posedge clk) begin
                        if (rst)
                                held <= 1'b0;
                        else
                                held <= push | (held & ~pop); // Push wins over pop
                end

                always_ff @(posedge clk) begin
                        if (push)
                                data_out <= data_in;
                end

                assign valid = held;
                assign full  = held;            // One slot only
        end else begin : g_multi
                localparam int IDX_W = $clog2(FIFO_DEPTH);

                logic [DATA_WIDTH-1:0] lut_ram [FIFO_DEPTH];
                logic [IDX_W-1:0]      write_index;
                logic [IDX_W-1:0]      read_index;
                logic [FIFO_DEPTH:0]   count_v; // One-hot, bit n = n entries

                // Head of queue shows without delay
                assign data_out = lut_ram[read_index];

                // Indices wrap at depth so non power of two depths work too
                always_ff @(posedge clk) begin
                        if (rst) begin
                                read_index  <= '0;
                                write_index <= '0;
                        end else begin
                                if (pop)
                                        read_index <= (read_index == IDX_W'(FIFO_DEPTH - 1)) ?
                                                      '0 : read_index + 1'b1;
                                if (push)
                                        write_index <= (write_index == IDX_W'(FIFO_DEPTH - 1)) ?
                                                       '0 : write_index + 1'b1;
                        end
                end

                always_ff @(posedge clk) begin
                        if (push)
                                lut_ram[write_index] <= data_in;
                end

                // Shift up on push alone, down on pop alone, hold otherwise
                always_ff @(posedge clk) begin
                        if (rst)
                                count_v <= {{FIFO_DEPTH{1'b0}}, 1'b1};
                        else if (push & ~pop)
                                count_v <= {count_v[FIFO_DEPTH-1:0], 1'b0};
                        else if (~push & pop)
                                count_v <= {1'b0, count_v[FIFO_DEPTH:1]};
                end

                assign full  = count_v[FIFO_DEPTH];
                assign valid = ~count_v[0];     // Not at zero entries
        end endgenerate

endmodule

// File: verilog/l2_arbiter_ctrl.sv
/*
 * L2 arbiter control
 * Round-robin choice between the request FIFOs, FIFO pops, read-ID push
 * and load of the memory-facing output register
 */
`timescale 1ns/1ps

module l2_arbiter_ctrl import l2_pkg::*; (
        input  logic                    clk,
        input  logic                    rst,
        input  logic [L2_NUM_PORTS-1:0] fifo_valid,
        input  logic [L2_NUM_PORTS-1:0] fifo_rnw,
        input  logic                    id_full,
        input  logic                    mem_req_ack,
        output logic [L2_NUM_PORTS-1:0] fifo_pop,
        output l2_id_t                  grant,
        output logic                    load,
        output logic                    mem_req_valid,
        output logic                    id_push
);

        l2_ctrl_state_t          state;
        l2_id_t                  last_grant;    // Port granted most recently
        logic [L2_NUM_PORTS-1:0] eligible;
        logic                    slot_free;

        // A read may only go out while there is room to record its owner
        assign eligible = fifo_valid & ~(fifo_rnw & {L2_NUM_PORTS{id_full}});

        // Register empty, or the current request leaves on this edge
        assign slot_free = (state == st_idle) | mem_req_ack;

        always_comb begin
                case (eligible)
                        2'b01:   grant = l2_id_t'(0);
                        2'b10:   grant = l2_id_t'(1);
                        2'b11:   grant = ~last_grant;   // Tie goes to the other port
                        default: grant = last_grant;    // Nothing to grant
                endcase
        end

        assign load = slot_free & (|eligible);

        always_comb begin
                fifo_pop = '0;
                if (load)
                        fifo_pop[grant] = 1'b1; // Pop on the same edge as the load
        end

        assign id_push = load & fifo_rnw[grant];

        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= st_idle;
                end else begin
                        case (state)
                                st_idle: begin
                                        if (load)
                                                state <= st_loaded;
                                end
                                st_loaded: begin
                                        // Back to back load keeps it occupied
                                        if (mem_req_ack & ~load)
                                                state <= st_idle;
                                end
                                default: state <= st_idle;
                        endcase
                end
        end

        // Start with port 0 favoured on the first tie
        always_ff @(posedge clk) begin
                if (rst)
                        last_grant <= l2_id_t'(1);
                else if (load)
                        last_grant <= grant;
        end

        assign mem_req_valid = (state == st_loaded);

endmodule

// File: verilog/l2_request_mux.sv
/*
 * L2 request mux
 * Picks the granted FIFO entry, unpacks it and holds the fields in the
 * output register that faces memory
 */
`timescale 1ns/1ps

module l2_request_mux import l2_pkg::*; (
        input  logic                         clk,
        input  logic                         load,
        input  l2_id_t                       grant,
        input  l2_req_t [L2_NUM_PORTS-1:0]   fifo_entry,
        output l2_addr_t                     mem_req_addr,
        output logic                         mem_req_rnw,
        output l2_data_t                     mem_req_wdata,
        output l2_id_t                       id_out
);

        l2_req_t  sel_entry;
        l2_addr_t sel_addr;
        logic     sel_rnw;
        l2_data_t sel_wdata;

        assign sel_entry = fifo_entry[grant];

        // Field split matches the packing in the package
        assign sel_addr  = sel_entry[l2_req_width-1 -: $bits(l2_addr_t)];
        assign sel_rnw   = sel_entry[$bits(l2_data_t)];
        assign sel_wdata = sel_entry[$bits(l2_data_t)-1:0];

        // Payload only, occupancy is tracked by the control FSM
        always_ff @(posedge clk) begin
                if (load) begin
                        mem_req_addr  <= sel_addr;
                        mem_req_rnw   <= sel_rnw;
                        mem_req_wdata <= sel_wdata;
                end
        end

        // Owner of a read, pushed into the ID FIFO with the load
        assign id_out = grant;

endmodule

// File: verilog/l2_response_router.sv
/*
 * L2 response router
 * Each memory read response pops the owner from the ID FIFO and is
 * registered toward that requestor
 */
`timescale 1ns/1ps

module l2_response_router import l2_pkg::*; (
        input  logic                    clk,
        input  logic                    rst,
        input  logic                    mem_rd_valid,
        input  l2_data_t                mem_rd_data,
        input  l2_id_t                  id_head,
        output logic                    id_pop,
        output logic [L2_NUM_PORTS-1:0] rd_valid,
        output l2_data_t                rd_data
);

        logic [L2_NUM_PORTS-1:0] owner_onehot;

        // Responses come in order, so the head is always the owner
        assign id_pop = mem_rd_valid;

        always_comb begin
                owner_onehot = '0;
                owner_onehot[id_head] = 1'b1;
        end

        always_ff @(posedge clk) begin
                if (rst)
                        rd_valid <= '0;
                else if (mem_rd_valid)
                        rd_valid <= owner_onehot;       // Single pulse on the owning port
                else
                        rd_valid <= '0;
        end

        // Data needs no reset, qualified by rd_valid
        always_ff @(posedge clk) begin
                if (mem_rd_valid)
                        rd_data <= mem_rd_data;
        end

endmodule

// File: verilog/l2_arbiter_top.sv
/*
 * L2 request arbiter
 * Two requestors share one memory port through per-port request FIFOs,
 * a round-robin control, a registered output stage and an in-order
 * read-ID FIFO used to route responses back
 */
`timescale 1ns/1ps

module l2_arbiter_top import l2_pkg::*; #(
        parameter int REQ_DEPTH = 4,            // Entries per request FIFO
        parameter int ID_DEPTH  = 4             // Reads outstanding at most
) (
        input  logic                             clk,
        input  logic                             rst,

        // Requestor side, indexed by port
        input  logic [L2_NUM_PORTS-1:0]          req_push,
        input  l2_addr_t [L2_NUM_PORTS-1:0]      req_addr,
        input  logic [L2_NUM_PORTS-1:0]          req_rnw,
        input  l2_data_t [L2_NUM_PORTS-1:0]      req_wdata,
        output logic [L2_NUM_PORTS-1:0]          req_full,
        output logic [L2_NUM_PORTS-1:0]          rd_valid,
        output l2_data_t                         rd_data,

        // Memory side
        output logic                             mem_req_valid,
        output l2_addr_t                         mem_req_addr,
        output logic                             mem_req_rnw,
        output l2_data_t                         mem_req_wdata,
        input  logic                             mem_req_ack,
        input  logic                             mem_rd_valid,
        input  l2_data_t                         mem_rd_data
);

        l2_req_t [L2_NUM_PORTS-1:0] req_entry;  // Packed request into each FIFO
        l2_req_t [L2_NUM_PORTS-1:0] fifo_entry; // Head of each FIFO
        logic [L2_NUM_PORTS-1:0]    fifo_valid;
        logic [L2_NUM_PORTS-1:0]    fifo_rnw;
        logic [L2_NUM_PORTS-1:0]    fifo_pop;
        l2_id_t                     grant;
        logic                       load;
        logic                       id_push;
        logic                       id_pop;
        logic                       id_full;
        l2_id_t                     id_in;
        l2_id_t                     id_head;

        for (genvar p = 0; p < L2_NUM_PORTS; p++) begin : g_port
                assign req_entry[p] = {req_addr[p], req_rnw[p], req_wdata[p]};
                assign fifo_rnw[p]  = fifo_entry[p][$bits(l2_data_t)]; // Head rnw bit

                l2_fifo #(
                        .DATA_WIDTH (l2_req_width),
                        .FIFO_DEPTH (REQ_DEPTH)
                ) u_req_fifo (
                        .clk      (clk),
                        .rst      (rst),
                        .push     (req_push[p]),
                        .pop      (fifo_pop[p]),
                        .data_in  (req_entry[p]),
                        .data_out (fifo_entry[p]),
                        .valid    (fifo_valid[p]),
                        .full     (req_full[p])
                );
        end

        l2_arbiter_ctrl u_ctrl (
                .clk           (clk),
                .rst           (rst),
                .fifo_valid    (fifo_valid),
                .fifo_rnw      (fifo_rnw),
                .id_full       (id_full),
                .mem_req_ack   (mem_req_ack),
                .fifo_pop      (fifo_pop),
                .grant         (grant),
                .load          (load),
                .mem_req_valid (mem_req_valid),
                .id_push       (id_push)
        );

        l2_request_mux u_mux (
                .clk           (clk),
                .load          (load),
                .grant         (grant),
                .fifo_entry    (fifo_entry),
                .mem_req_addr  (mem_req_addr),
                .mem_req_rnw   (mem_req_rnw),
                .mem_req_wdata (mem_req_wdata),
                .id_out        (id_in)
        );

        // Owner of every read in flight, oldest at the head
        l2_fifo #(
                .DATA_WIDTH ($bits(l2_id_t)),
                .FIFO_DEPTH (ID_DEPTH)
        ) u_id_fifo (
                .clk      (clk),
                .rst      (rst),
                .push     (id_push),
                .pop      (id_pop),
                .data_in  (id_in),
                .data_out (id_head),
                .valid    (),
                .full     (id_full)
        );

        l2_response_router u_router (
                .clk          (clk),
                .rst          (rst),
                .mem_rd_valid (mem_rd_valid),
                .mem_rd_data  (mem_rd_data),
                .id_head      (id_head),
                .id_pop       (id_pop),
                .rd_valid     (rd_valid),
                .rd_data      (rd_data)
        );

endmodule

// File: verif/tb_clock_gen.sv
/*
 * Testbench clock and reset
 * 100 ns clock, reset held high for the first 10 rising edges
 */
`timescale 1ns/1ps

module tb_clock_gen #(
        parameter int RESET_CYCLES = 10
) (
        output logic clk,
        output logic rst
);

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;         // 100 ns period
        end

        initial begin
                rst = 1'b1;
                repeat (RESET_CYCLES) @(posedge clk);
                #1 rst = 1'b0;                  // Released with the other stimulus
        end

endmodule

// File: verif/l2_arbiter_assert.sv
/*
 * L2 arbiter assertions
 * Memory-side request hold, single-port read pulses and FIFO overflow
 */
`timescale 1ns/1ps

module l2_arbiter_assert import l2_pkg::*; (
        input logic                    clk,
        input logic                    rst,
        input logic [L2_NUM_PORTS-1:0] req_push,
        input logic [L2_NUM_PORTS-1:0] req_full,
        input logic                    id_push,
        input logic                    id_full,
        input logic [L2_NUM_PORTS-1:0] rd_valid,
        input logic                    mem_req_valid,
        input logic                    mem_req_ack,
        input l2_addr_t                mem_req_addr,
        input logic                    mem_req_rnw,
        input l2_data_t                mem_req_wdata
);

        // Request held until memory takes it
        hold_until_ack: assert property (@(posedge clk) disable iff (rst)
                mem_req_valid && !mem_req_ack |=> mem_req_valid && $stable(mem_req_addr)
                        && $stable(mem_req_rnw) && $stable(mem_req_wdata))
                else $error("Memory request changed before it was acked");

        rd_single_port: assert property (@(posedge clk) disable iff (rst) $onehot0(rd_valid))
                else $error("Read response sent to more than one port");

        no_req_overflow: assert property (@(posedge clk) disable iff (rst)
                (req_push & req_full) == '0)
                else $error("Push into a full request FIFO");

        no_id_overflow: assert property (@(posedge clk) disable iff (rst) !(id_push && id_full))
                else $error("Push into a full read-ID FIFO");

endmodule

bind l2_arbiter_top l2_arbiter_assert u_assert (.*);

// File: verif/tb_l2_arbiter.sv
/*
 * L2 arbiter testbench
 * Directed tests for reset, single write, round-robin fairness, read
 * routing and back-pressure, with a memory model and request scoreboard
 */
`timescale 1ns/1ps

module tb_l2_arbiter import l2_pkg::*; ();

        localparam int REQ_DEPTH  = 4;
        localparam int ID_DEPTH   = 4;
        localparam int MAX_CYCLES = 2000;               // Ample margin over the test length
        localparam int PORT_BIT   = $bits(l2_addr_t) - 1; // Stimulus tags the port here

        typedef struct packed {
                l2_addr_t addr;
                logic     rnw;
                l2_data_t wdata;
        } tb_req_t;

        logic                        clk;
        logic                        rst;
        logic [L2_NUM_PORTS-1:0]     req_push;
        l2_addr_t [L2_NUM_PORTS-1:0] req_addr;
        logic [L2_NUM_PORTS-1:0]     req_rnw;
        l2_data_t [L2_NUM_PORTS-1:0] req_wdata;
        logic [L2_NUM_PORTS-1:0]     req_full;
        logic [L2_NUM_PORTS-1:0]     rd_valid;
        l2_data_t                    rd_data;
        logic                        mem_req_valid;
        l2_addr_t                    mem_req_addr;
        logic                        mem_req_rnw;
        l2_data_t                    mem_req_wdata;
        logic                        mem_req_ack;
        logic                        mem_rd_valid;
        l2_data_t                    mem_rd_data;

        tb_req_t  exp_q0[$];                            // Pushed but not yet taken by memory
        tb_req_t  exp_q1[$];
        l2_addr_t mem_pend_q[$];                        // Reads waiting for memory data
        l2_addr_t chk_addr_q[$];                        // Reads with response not yet checked
        l2_id_t   taken_port_q[$];                      // Port of each request memory took
        logic     ack_enable;
        logic     rd_enable;                            // Memory may return read data
        logic     rd_due;                               // rd_valid expected this cycle
        l2_id_t   rd_due_owner;
        l2_data_t rd_due_data;
        int       rd_seen;
        int       value_errors;
        int       other_errors;
        int       cycle_count;

        tb_clock_gen u_clk (.clk (clk), .rst (rst));

        l2_arbiter_top #(.REQ_DEPTH (REQ_DEPTH), .ID_DEPTH (ID_DEPTH)) u_dut (.*);

        // Memory contents are the inverted address zero extended
        function automatic l2_data_t mem_word(input l2_addr_t addr);
                return {2'b00, ~addr};
        endfunction

        task automatic report_problem(input string what);
                other_errors++;
                $display("ERROR at %0t: %s", $time, what);
        endtask

        task automatic compare_addr(input l2_addr_t got, input l2_addr_t want, input string what);
                if (got !== want) begin
                        value_errors++;
                        $display("FAILED at %0t: %s is 0x%08h, expected 0x%08h",
                                 $time, what, got, want);
                end
        endtask

        task automatic compare_data(input l2_data_t got, input l2_data_t want, input string what);
                if (got !== want) begin
                        value_errors++;
                        $display("FAILED at %0t: %s is 0x%08h, expected 0x%08h",
                                 $time, what, got, want);
                end
        endtask

        task automatic compare_id(input l2_id_t got, input l2_id_t want, input string what);
                if (got !== want) begin
                        value_errors++;
                        $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, want);
                end
        endtask

        task automatic compare_flag(input logic got, input logic want, input string what);
                if (got !== want) begin
                        value_errors++;
                        $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, want);
                end
        endtask

        task automatic compare_count(input int got, input int want, input string what);
                if (got != want) begin
                        value_errors++;
                        $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, want);
                end
        endtask

        // Stimulus changes 1 ns after the rising edge
        task automatic next_cycle;
                @(posedge clk);
                #1;
        endtask

        // Drive one request for the coming edge and log it as expected
        task automatic queue_request(input int port, input logic rnw);
                tb_req_t req;
                req.addr           = l2_addr_t'($urandom());
                req.addr[PORT_BIT] = port[0];
                req.rnw            = rnw;
                req.wdata          = $urandom();
                if (req_full[port]) begin
                        report_problem($sformatf("port %0d full when a push was due", port));
                        return;
                end
                req_push[port]  = 1'b1;
                req_addr[port]  = req.addr;
                req_rnw[port]   = rnw;
                req_wdata[port] = req.wdata;
                if (port == 0)
                        exp_q0.push_back(req);
                else
                        exp_q1.push_back(req);
        endtask

        task automatic wait_drained;
                while (exp_q0.size() != 0 || exp_q1.size() != 0 ||
                       chk_addr_q.size() != 0 || rd_due)
                        next_cycle;
                next_cycle;
        endtask

        // Request taken on the coming edge must match the head of its port queue
        task automatic check_taken;
                tb_req_t want;
                l2_id_t  port;
                port = mem_req_addr[PORT_BIT];
                if ((port == 1'b0 && exp_q0.size() == 0) ||
                    (port == 1'b1 && exp_q1.size() == 0)) begin
                        report_problem($sformatf("memory got a request port %0d never sent", port));
                        return;
                end
                if (port == 1'b0)
                        want = exp_q0.pop_front();
                else
                        want = exp_q1.pop_front();
                compare_addr(mem_req_addr, want.addr, "request address");
                compare_flag(mem_req_rnw, want.rnw, "request rnw");
                compare_data(mem_req_wdata, want.wdata, "request write data");
                taken_port_q.push_back(port);
                if (want.rnw) begin
                        mem_pend_q.push_back(want.addr);
                        chk_addr_q.push_back(want.addr);
                end
        endtask

        // Scoreboard samples on the falling edge where all signals are settled
        initial begin
                l2_addr_t rd_addr;
                rd_due = 1'b0;
                rd_seen = 0;
                forever begin
                        @(negedge clk);
                        if (!rst) begin
                                if (rd_due) begin
                                        if (!$onehot(rd_valid))
                                                report_problem("read response not on exactly one port");
                                        compare_id(l2_id_t'(rd_valid[1]), rd_due_owner, "read owner");
                                        compare_data(rd_data, rd_due_data, "read data");
                                        rd_seen += $countones(rd_valid);
                                end else if (rd_valid != '0) begin
                                        report_problem("rd_valid pulsed without a memory response");
                                end
                                rd_due = mem_rd_valid;  // Router output due next cycle
                                if (mem_rd_valid) begin
                                        rd_addr      = chk_addr_q.pop_front();
                                        rd_due_owner = rd_addr[PORT_BIT];
                                        rd_due_data  = mem_word(rd_addr);
                                end
                                if (mem_req_valid && mem_req_ack)
                                        check_taken;
                        end
                end
        end

        // Memory model acks and returns read data on command
        initial begin
                mem_req_ack  = 1'b0;
                mem_rd_valid = 1'b0;
                mem_rd_data  = '0;
                forever begin
                        next_cycle;
                        mem_req_ack  = ack_enable & mem_req_valid;
                        mem_rd_valid = rd_enable && (mem_pend_q.size() != 0);
                        if (mem_rd_valid)
                                mem_rd_data = mem_word(mem_pend_q.pop_front());
                end
        end

        initial begin
                cycle_count = 0;
                while (cycle_count < MAX_CYCLES) begin
                        @(posedge clk);
                        cycle_count++;
                end
                $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
                $display("CHECKS FAILED");
                $finish;
        end

        // Ten reset cycles and three after
        task automatic test_reset;
                repeat (13) begin
                        @(negedge clk);
                        compare_flag(mem_req_valid, 1'b0, "mem_req_valid around reset");
                        compare_flag(|rd_valid, 1'b0, "rd_valid around reset");
                        compare_flag(|req_full, 1'b0, "req_full around reset");
                end
                next_cycle;
        endtask

        task automatic test_single_write;
                tb_req_t sent;
                ack_enable = 1'b0;
                queue_request(1, 1'b0);
                sent = exp_q1[$];
                next_cycle;
                req_push = '0;
                compare_flag(mem_req_valid, 1'b0, "mem_req_valid 1 cycle after push");
                next_cycle;
                compare_flag(mem_req_valid, 1'b1, "mem_req_valid 2 cycles after push");
                compare_addr(mem_req_addr, sent.addr, "single write address");
                compare_flag(mem_req_rnw, 1'b0, "single write rnw");
                compare_data(mem_req_wdata, sent.wdata, "single write data");
                ack_enable = 1'b1;
                wait_drained;
        endtask

        task automatic test_fairness;
                taken_port_q.delete();
                ack_enable = 1'b0;                      // Let both FIFOs fill first
                repeat (3) begin
                        queue_request(0, 1'b0);
                        queue_request(1, 1'b0);
                        next_cycle;
                        req_push = '0;
                end
                ack_enable = 1'b1;
                wait_drained;
                compare_id(taken_port_q[0], l2_id_t'(0), "first port after a port 1 grant");
                for (int i = 1; i < taken_port_q.size(); i++)
                        compare_id(taken_port_q[i], ~taken_port_q[i-1], "round-robin port");
        endtask

        task automatic test_read_routing;
                int start;
                start = rd_seen;
                ack_enable = 1'b1;
                rd_enable  = 1'b0;                      // Hold data so the ID FIFO fills
                repeat (4) begin
                        queue_request(0, 1'b1);
                        queue_request(1, 1'b1);
                        next_cycle;
                        req_push = '0;
                end
                while (mem_pend_q.size() < ID_DEPTH)
                        next_cycle;
                repeat (3) next_cycle;
                compare_count(mem_pend_q.size(), ID_DEPTH, "reads taken with ID FIFO full");
                rd_enable = 1'b1;
                wait_drained;
                compare_count(rd_seen - start, 8, "read responses");
        endtask

        task automatic test_back_pressure;
                int accepted;
                accepted = 0;
                ack_enable = 1'b0;
                while (!req_full[0] && accepted < REQ_DEPTH + 3) begin
                        queue_request(0, 1'($urandom_range(0, 1)));
                        next_cycle;
                        req_push = '0;
                        accepted++;
                end
                compare_count(accepted, REQ_DEPTH + 1, "pushes accepted before full");
                ack_enable = 1'b1;
                wait_drained;
                compare_flag(req_full[0], 1'b0, "req_full after drain");
        endtask

        initial begin
                req_push     = '0;
                req_addr     = '0;
                req_rnw      = '0;
                req_wdata    = '0;
                ack_enable   = 1'b0;
                rd_enable    = 1'b1;
                value_errors = 0;
                other_errors = 0;
                void'($urandom(32'h0472_6393));
                test_reset;
                test_single_write;
                test_fairness;
                test_read_routing;
                test_back_pressure;
                $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
                if (value_errors == 0 && other_errors == 0)
                        $display("ALL CHECKS PASSED");
                else
                        $display("CHECKS FAILED");
                $finish;
        end

endmodule

// File: sources.f
verilog/l2_pkg.sv
verilog/l2_fifo.sv
verilog/l2_arbiter_ctrl.sv
verilog/l2_request_mux.sv
verilog/l2_response_router.sv
verilog/l2_arbiter_top.sv
verif/tb_clock_gen.sv
verif/l2_arbiter_assert.sv
verif/tb_l2_arbiter.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the L2 arbiter testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -j 0 --top-module tb_l2_arbiter -Mdir obj_dir -f sources.f \
        > "$LOG" 2>&1 &&
./obj_dir/Vtb_l2_arbiter >> "$LOG" 2>&1 ||
{ cat "$LOG"; echo "Build or simulation error"; exit 1; }

cat "$LOG"
grep -q "CHECKS FAILED" "$LOG" && { echo "Simulation failed"; exit 1; } ||
echo "Simulation passed"
